// ==== hdl/loader_pkg.sv ====
package loader_pkg;

    localparam int CORES      = 4;
    localparam int INSN_WORDS = 64;    // per core
    localparam int DATA_WORDS = 128;   // per core
    localparam int LINE_BITS  = 512;
    localparam int LINE_WORDS = 16;
    localparam int LINE_BYTES = 64;    // address step per line

    // one memory word and one bus line
    typedef logic [31:0] word_t;
    typedef logic [LINE_BITS-1:0] line_t;

    // byte address on the master
    typedef logic [63:0] mem_addr_t;

    typedef logic [$clog2(CORES)-1:0] core_t;

    // sized for the data image
    typedef logic [$clog2(DATA_WORDS)-1:0] word_index_t;

    // 12 lines from the image base
    typedef logic [3:0] line_index_t;

endpackage

// ==== hdl/loader_ctrl.sv ====
module loader_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    kick,
    input  loader_pkg::core_t       target_core,
    input  logic                    line_ready,
    output logic                    busy,
    output logic                    start,
    output logic                    line_req,
    output loader_pkg::line_index_t line_index,
    output logic                    word_we,
    output logic                    shift,
    output logic                    word_is_data,
    output loader_pkg::word_index_t word_index,
    output loader_pkg::core_t       core_sel
);
    import loader_pkg::*;

    enum logic [2:0] {
        IDLE,
        REQ,
        WAIT_LINE,
        WRITE_INSN,
        WRITE_DATA
    } state;

    line_index_t line_cnt;
    word_index_t word_cnt;
    core_t       core_q;
    logic        group_done;
    logic        insn_phase;

    assign group_done = &word_cnt[$clog2(LINE_WORDS)-1:0];    // last word of the line
    assign insn_phase = line_cnt < line_index_t'(INSN_WORDS / LINE_WORDS);

    assign start        = kick && (state == IDLE);
    assign busy         = start || (state != IDLE);
    assign line_req     = (state == REQ);
    assign line_index   = line_cnt;
    assign word_we      = (state == WRITE_INSN) || (state == WRITE_DATA);
    assign shift        = word_we;    // one word leaves the line per write
    assign word_is_data = (state == WRITE_DATA);
    assign word_index   = word_cnt;
    assign core_sel     = core_q;

    always_ff @(posedge clk) begin
        if (start) begin
            core_q <= target_core;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            line_cnt <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (kick) begin
                        state    <= REQ;
                        line_cnt <= '0;
                        word_cnt <= '0;
                    end
                end
                REQ: begin
                    state <= WAIT_LINE;
                end
                WAIT_LINE: begin
                    if (line_ready) begin
                        if (insn_phase) begin
                            state <= WRITE_INSN;
                        end else begin
                            state <= WRITE_DATA;
                        end
                    end
                end
                WRITE_INSN: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (group_done) begin
                        line_cnt <= line_cnt + 1'b1;
                        state    <= REQ;
                        if (word_cnt == word_index_t'(INSN_WORDS - 1)) begin
                            word_cnt <= '0;    // data image starts at word 0
                        end
                    end
                end
                WRITE_DATA: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (group_done) begin
                        line_cnt <= line_cnt + 1'b1;
                        if (word_cnt == word_index_t'(DATA_WORDS - 1)) begin
                            state <= IDLE;
                        end else begin
                            state <= REQ;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/mem_read_port.sv ====
module mem_read_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  loader_pkg::mem_addr_t   base_addr,
    input  logic                    line_req,
    input  loader_pkg::line_index_t line_index,
    input  logic                    m0_waitrequest,
    output logic                    m0_read,
    output loader_pkg::mem_addr_t   m0_address
);
    import loader_pkg::*;

    mem_addr_t base_q;
    mem_addr_t line_offset;

    // line index times the line size in bytes
    assign line_offset = mem_addr_t'(line_index) << $clog2(LINE_BYTES);

    always_ff @(posedge clk) begin
        if (start) begin
            base_q <= base_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (line_req) begin
            m0_address <= base_q + line_offset;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m0_read <= 1'b0;
        end else if (line_req) begin
            m0_read <= 1'b1;
        end else if (!m0_waitrequest) begin
            m0_read <= 1'b0;    // accepted this cycle
        end
    end

endmodule

// ==== hdl/line_unpacker.sv ====
module line_unpacker (
    input  logic              clk,
    input  logic              reset,
    input  logic              m0_readdatavalid,
    input  loader_pkg::line_t m0_readdata,
    input  logic              shift,
    output logic              line_ready,
    output loader_pkg::word_t word
);
    import loader_pkg::*;

    line_t line_q;

    // most significant word goes out first
    assign word = line_q[LINE_BITS-1 -: $bits(word_t)];

    always_ff @(posedge clk) begin
        if (m0_readdatavalid) begin
            line_q <= m0_readdata;
        end else if (shift) begin
            line_q <= line_q << $bits(word_t);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            line_ready <= 1'b0;
        end else begin
            line_ready <= m0_readdatavalid;
        end
    end

endmodule

// ==== hdl/core_mem_bank.sv ====
module core_mem_bank (
    input  logic                    clk,
    input  logic                    word_we,
    input  logic                    word_is_data,
    input  loader_pkg::core_t       core_sel,
    input  loader_pkg::word_index_t word_index,
    input  loader_pkg::word_t       word,
    input  loader_pkg::core_t       fetch_core,
    input  logic                    fetch_is_data,
    input  loader_pkg::word_index_t fetch_index,
    output loader_pkg::word_t       fetch_data
);
    import loader_pkg::*;

    localparam int INSN_AW = $clog2(INSN_WORDS);

    word_t insn_mem [CORES][INSN_WORDS];
    word_t data_mem [CORES][DATA_WORDS];

    logic [INSN_AW-1:0] wr_insn_addr;
    logic [INSN_AW-1:0] rd_insn_addr;

    // instruction image uses the low index bits only
    assign wr_insn_addr = word_index[INSN_AW-1:0];
    assign rd_insn_addr = fetch_index[INSN_AW-1:0];

    always_ff @(posedge clk) begin
        if (word_we) begin
            if (word_is_data) begin
                data_mem[core_sel][word_index] <= word;
            end else begin
                insn_mem[core_sel][wr_insn_addr] <= word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_is_data) begin
            fetch_data <= data_mem[fetch_core][fetch_index];
        end else begin
            fetch_data <= insn_mem[fetch_core][rd_insn_addr];
        end
    end

endmodule

// ==== hdl/core_image_loader.sv ====
module core_image_loader (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    kick,
    input  loader_pkg::mem_addr_t   base_addr,
    input  loader_pkg::core_t       target_core,
    output logic                    busy,
    output logic                    m0_read,
    output loader_pkg::mem_addr_t   m0_address,
    input  logic                    m0_waitrequest,
    input  loader_pkg::line_t       m0_readdata,
    input  logic                    m0_readdatavalid,
    input  loader_pkg::core_t       fetch_core,
    input  logic                    fetch_is_data,
    input  loader_pkg::word_index_t fetch_index,
    output loader_pkg::word_t       fetch_data
);
    import loader_pkg::*;

    logic        start;
    logic        line_req;
    line_index_t line_index;
    logic        line_ready;
    logic        word_we;
    logic        shift;
    logic        word_is_data;
    word_index_t word_index;
    core_t       core_sel;
    word_t       word;

    loader_ctrl loader_ctrl_inst (
        .clk          (clk),
        .reset        (reset),
        .kick         (kick),
        .target_core  (target_core),
        .line_ready   (line_ready),
        .busy         (busy),
        .start        (start),
        .line_req     (line_req),
        .line_index   (line_index),
        .word_we      (word_we),
        .shift        (shift),
        .word_is_data (word_is_data),
        .word_index   (word_index),
        .core_sel     (core_sel)
    );

    mem_read_port mem_read_port_inst (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .base_addr      (base_addr),
        .line_req       (line_req),
        .line_index     (line_index),
        .m0_waitrequest (m0_waitrequest),
        .m0_read        (m0_read),
        .m0_address     (m0_address)
    );

    line_unpacker line_unpacker_inst (
        .clk              (clk),
        .reset            (reset),
        .m0_readdatavalid (m0_readdatavalid),
        .m0_readdata      (m0_readdata),
        .shift            (shift),
        .line_ready       (line_ready),
        .word             (word)
    );

    core_mem_bank core_mem_bank_inst (
        .clk           (clk),
        .word_we       (word_we),
        .word_is_data  (word_is_data),
        .core_sel      (core_sel),
        .word_index    (word_index),
        .word          (word),
        .fetch_core    (fetch_core),
        .fetch_is_data (fetch_is_data),
        .fetch_index   (fetch_index),
        .fetch_data    (fetch_data)
    );

endmodule

// ==== testbench/avalon_mem_model.sv ====
module avalon_mem_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read,
    input  loader_pkg::mem_addr_t address,
    output logic                  waitrequest,
    output loader_pkg::line_t     readdata,
    output logic                  readdatavalid
);
    timeunit 1ns;
    timeprecision 100ps;

    import loader_pkg::*;

    localparam int MEM_LINES = 64;
    localparam int LINE_SEL  = $clog2(MEM_LINES);

    line_t  mem [MEM_LINES];    // filled by the testbench at time zero
    integer seed = 32'hb8be_7734;
    int     stall_left;
    int     latency_left;
    logic   pending;
    logic [LINE_SEL-1:0] pending_line;

    // stall count is drawn ahead of each request
    assign waitrequest = read && (stall_left != 0);

    always @(posedge clk) begin
        if (reset) begin
            stall_left    <= {$random(seed)} % 4;
            latency_left  <= 0;
            pending       <= 1'b0;
            pending_line  <= '0;
            readdata      <= '0;
            readdatavalid <= 1'b0;
        end else begin
            readdatavalid <= 1'b0;
            if (pending) begin
                if (latency_left == 1) begin
                    readdatavalid <= 1'b1;
                    readdata      <= mem[pending_line];
                    pending       <= 1'b0;
                end else begin
                    latency_left <= latency_left - 1;
                end
            end
            if (read && stall_left != 0) begin
                stall_left <= stall_left - 1;
            end else if (read) begin    // accepted
                pending      <= 1'b1;
                pending_line <= address[$clog2(LINE_BYTES) +: LINE_SEL];
                latency_left <= 1 + {$random(seed)} % 8;
                stall_left   <= {$random(seed)} % 4;    // stalls for the next request
            end
        end
    end

endmodule

// ==== testbench/core_image_loader_props.sv ====
module core_image_loader_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  line_ready,
    input logic                  word_we,
    input logic                  m0_read,
    input logic                  m0_waitrequest,
    input loader_pkg::mem_addr_t m0_address
);
    timeunit 1ns;
    timeprecision 100ps;

    request_held: assert property (@(posedge clk) disable iff (reset)
        m0_read && m0_waitrequest |=> m0_read && $stable(m0_address))
        else $error("read request dropped or moved while waitrequest was high");

    writes_follow_line: assert property (@(posedge clk) disable iff (reset)
        $rose(word_we) |-> $past(line_ready))
        else $error("memory writes started without a returned line");

    read_low_after_reset: assert property (@(posedge clk)
        reset |=> !m0_read)
        else $error("read request high in the cycle after reset");

endmodule

bind core_image_loader core_image_loader_props core_image_loader_props_inst (
    .clk            (clk),
    .reset          (reset),
    .line_ready     (line_ready),
    .word_we        (word_we),
    .m0_read        (m0_read),
    .m0_waitrequest (m0_waitrequest),
    .m0_address     (m0_address)
);

// ==== testbench/core_image_loader_tb.sv ====
module core_image_loader_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import loader_pkg::*;

    localparam int MEM_LINES    = 64;
    localparam int LOAD_LINES   = (INSN_WORDS + DATA_WORDS) / LINE_WORDS;
    localparam int LINE_CYCLES  = 32;    // request, stalls, latency, capture, writes
    localparam int IMAGE_CYCLES = 2 * (INSN_WORDS + DATA_WORDS) + 2;
    localparam int TIMEOUT_CYCLES = 10 + CORES * (LOAD_LINES * LINE_CYCLES + 4)
                                    + 2 * CORES * IMAGE_CYCLES;
    localparam int STRAY_KICK_CYCLE = 40;

    logic        clk;
    logic        reset;
    logic        kick;
    mem_addr_t   base_addr;
    core_t       target_core;
    logic        busy;
    logic        m0_read;
    mem_addr_t   m0_address;
    logic        m0_waitrequest;
    line_t       m0_readdata;
    logic        m0_readdatavalid;
    core_t       fetch_core;
    logic        fetch_is_data;
    word_index_t fetch_index;
    word_t       fetch_data;

    integer      seed = 32'hb8be_7734;
    line_t       ref_lines [MEM_LINES];
    int          core_line [CORES];    // first image line per core
    mem_addr_t   load_base;
    int          reads_start;
    int          read_total = 0;
    int          cycle_count = 0;

    core_image_loader core_image_loader_inst (
        .clk              (clk),
        .reset            (reset),
        .kick             (kick),
        .base_addr        (base_addr),
        .target_core      (target_core),
        .busy             (busy),
        .m0_read          (m0_read),
        .m0_address       (m0_address),
        .m0_waitrequest   (m0_waitrequest),
        .m0_readdata      (m0_readdata),
        .m0_readdatavalid (m0_readdatavalid),
        .fetch_core       (fetch_core),
        .fetch_is_data    (fetch_is_data),
        .fetch_index      (fetch_index),
        .fetch_data       (fetch_data)
    );

    avalon_mem_model mem_model_inst (
        .clk           (clk),
        .reset         (reset),
        .read          (m0_read),
        .address       (m0_address),
        .waitrequest   (m0_waitrequest),
        .readdata      (m0_readdata),
        .readdatavalid (m0_readdatavalid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("error at time %0t: %s read %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_address(mem_addr_t got, mem_addr_t exp, string what);
        if (got !== exp) begin
            $display("error at time %0t: %s was %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_busy(bit got, bit exp, string what);
        if (got !== exp) begin
            $display("error at time %0t: %s was %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // word 0 of a line is its top 32 bits and data follows the instruction image
    function automatic word_t expected_word(int first_line, bit is_data, int index);
        int pos;
        int slot;
        pos  = is_data ? INSN_WORDS + index : index;
        slot = pos % LINE_WORDS;
        return ref_lines[first_line + pos / LINE_WORDS][LINE_BITS - 1 - 32 * slot -: 32];
    endfunction

    task automatic fetch_and_check(core_t core, bit is_data, int index);
        string what;
        @(posedge clk);
        fetch_core    <= core;
        fetch_is_data <= is_data;
        fetch_index   <= word_index_t'(index);
        @(posedge clk);
        @(negedge clk);    // fetch_data registered at the edge before
        what = $sformatf("core %0d %s word %0d", core, is_data ? "data" : "insn", index);
        check_word(fetch_data, expected_word(core_line[core], is_data, index), what);
    endtask

    task automatic check_image(core_t core);
        for (int i = 0; i < INSN_WORDS; i++) begin
            fetch_and_check(core, 1'b0, i);
        end
        for (int j = 0; j < DATA_WORDS; j++) begin
            fetch_and_check(core, 1'b1, j);
        end
    endtask

    // one load and a second kick part way through that must be ignored
    task automatic run_load(core_t core, int first_line, core_t stray_core, int stray_line);
        int cycles;
        bit done;
        @(posedge clk);
        kick        <= 1'b1;
        base_addr   <= mem_addr_t'(first_line * LINE_BYTES);
        target_core <= core;
        load_base   = mem_addr_t'(first_line * LINE_BYTES);
        reads_start = read_total;
        @(negedge clk);
        check_busy(busy, 1'b1, "busy in the kick cycle");
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            kick <= (cycles == STRAY_KICK_CYCLE);
            if (cycles == STRAY_KICK_CYCLE) begin
                base_addr   <= mem_addr_t'(stray_line * LINE_BYTES);
                target_core <= stray_core;
            end
            @(negedge clk);
            if (cycles == STRAY_KICK_CYCLE) begin
                check_busy(busy, 1'b1, "busy during a kick mid-load");
            end
            done = !busy;
        end
        if (read_total - reads_start != LOAD_LINES) begin
            $display("load on core %0d made %0d line reads instead of %0d",
                     core, read_total - reads_start, LOAD_LINES);
            abort_run();
        end
        core_line[core] = first_line;
    endtask

    // accepted line reads counted per load
    always @(posedge clk) begin
        if (!reset && m0_read && !m0_waitrequest) begin
            if (!busy) begin
                $display("a line read was accepted while the loader was idle");
                abort_run();
            end
            check_address(m0_address,
                          load_base + mem_addr_t'(LINE_BYTES * (read_total - reads_start)),
                          "line read address");
            read_total <= read_total + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            abort_run();
        end
    end

    initial begin
        core_t core;
        int    first_line;
        int    stray_line;
        reset         <= 1'b1;
        kick          <= 1'b0;
        base_addr     <= '0;
        target_core   <= '0;
        fetch_core    <= '0;
        fetch_is_data <= 1'b0;
        fetch_index   <= '0;
        for (int n = 0; n < MEM_LINES; n++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                ref_lines[n][32 * w +: 32] = $random(seed);
            end
            mem_model_inst.mem[n] = ref_lines[n];
        end
        for (int c = 0; c < CORES; c++) begin
            core_line[c] = -1;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int k = 0; k < CORES; k++) begin
            core       = core_t'(k ^ 2);    // cores 2, 3, 0, 1
            first_line = {$random(seed)} % (MEM_LINES - LOAD_LINES + 1);
            stray_line = {$random(seed)} % (MEM_LINES - LOAD_LINES + 1);
            if (stray_line == first_line) begin
                stray_line = (stray_line + 1) % (MEM_LINES - LOAD_LINES + 1);
            end
            run_load(core, first_line, core_t'(core - 1), stray_line);
            check_image(core);
        end
        for (int c = 0; c < CORES; c++) begin
            check_image(core_t'(c));    // later loads left this core alone
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== core_image_loader.f ====
hdl/loader_pkg.sv
hdl/loader_ctrl.sv
hdl/mem_read_port.sv
hdl/line_unpacker.sv
hdl/core_mem_bank.sv
hdl/core_image_loader.sv
testbench/avalon_mem_model.sv
testbench/core_image_loader_props.sv
testbench/core_image_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module core_image_loader_tb -f core_image_loader.f -o core_image_loader_sim

status=0
./obj_dir/core_image_loader_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
